//--- osd_overlay.f
hw/osd_pkg.sv
hw/osd_raster_if.sv
hw/osd_cmd_fsm.sv
hw/osd_raster_counter.sv
hw/osd_char_buffer.sv
hw/osd_pixel_mixer.sv
hw/osd_overlay.sv
dv/osd_overlay_asserts.sv
dv/osd_overlay_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the OSD overlay simulation with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert --top-module osd_overlay_tb \
	-f osd_overlay.f -o osd_overlay_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/osd_overlay_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "SOME TESTS FAILED" "$log"; then
	echo "simulation failed"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$log"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
exit 0

//--- dv/osd_overlay_tb.sv
//--------------------------------------------------------------------------
// OSD overlay testbench
//--------------------------------------------------------------------------
module osd_overlay_tb;
	import osd_pkg::*;

	// Test raster, 320 by 80 active
	localparam int act_w = 320;
	localparam int line_len = 336;
	localparam int hs_begin = 324;
	localparam int hs_end = 332;
	localparam int vs_lines = 2;
	localparam int v_blank = 4;
	localparam int act_lines = 80;
	localparam int frame_lines = v_blank + act_lines;
	localparam int frame_cycles = line_len * frame_lines;
	localparam int h_start = (act_w - osd_width) / 2;
	localparam int v_start = (act_lines - osd_height) / 2;
	localparam int host_line = 20;
	localparam int num_steps = 6;

	typedef enum logic [2:0] {
		act_none,
		act_write,
		act_enable,
		act_disable,
		act_bad
	} host_act_e;

	typedef struct packed {
		host_act_e act;
		logic [2:0] block;
		logic [11:0] count;
		logic [3:0] frames;
		logic en;
	} step_t;

	logic clk_video = 1'b0;
	logic rst_n = 1'b0;
	logic io_osd = 1'b0;
	logic io_strobe = 1'b0;
	logic [15:0] io_din = '0;
	logic [23:0] din = '0;
	logic de_in = 1'b0;
	logic hs_in = 1'b0;
	logic vs_in = 1'b0;
	logic [23:0] dout;
	logic de_out;
	logic hs_out;
	logic vs_out;

	step_t steps [num_steps];
	logic [7:0] bitmap [buf_depth];
	logic [23:0] exp_video [$];
	logic [2:0] exp_sync [$];
	integer seed = 32'h796e_a9eb;
	logic video_run = 1'b0;
	logic model_enable = 1'b0;
	logic frame_en = 1'b0;
	int h_pos = 0;
	int v_pos = 0;
	int vs_rises = 0;
	int frame_count = 0;
	int cur_line = 0;
	int win_pixels = 0;

	osd_overlay osd_overlay_inst (.*);

	always #2 clk_video = ~clk_video;

	// Varies with every address bit and with each load
	function automatic logic [7:0] pattern_byte(input logic [buf_addr_w-1:0] addr,
			input int salt);
		return addr[7:0] * 8'd29 ^ {5'd0, addr[10:8]} * 8'd73 ^ addr[10:3] ^ 8'(salt * 91);
	endfunction

	function automatic logic [23:0] expected_blend(input logic [23:0] pix, input int col,
			input int row);
		logic [buf_addr_w-1:0] addr;
		logic [2:0] bsel;
		logic [7:0] bits;
		logic [23:0] res;
		addr = buf_addr_w'((row / 8) * osd_width + col);
		bsel = 3'(row % 8);
		bits = bitmap[addr];
		for (int c = 0; c < 3; c++) begin
			res[c*8 +: 8] = {bits[bsel], bits[bsel], osd_color[c], pix[c*8+3 +: 5]};
		end
		return res;
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_video(input string name, input logic [23:0] exp,
			input logic [23:0] act);
		if (act !== exp) begin
			fail_stop($sformatf("error t=%0t %s expected %h actual %h", $time, name, exp, act));
		end
	endtask

	task automatic check_sync(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp) begin
			fail_stop($sformatf("error t=%0t %s expected %b actual %b", $time, name, exp, act));
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_stop($sformatf("error t=%0t %s expected %b actual %b", $time, name, exp, act));
		end
	endtask

	task automatic send_word(input logic [15:0] w);
		@(posedge clk_video);
		io_din <= w;
		@(posedge clk_video);
		io_strobe <= 1'b1;
		@(posedge clk_video);
		@(posedge clk_video);
		io_strobe <= 1'b0;
	endtask

	task automatic close_frame();
		@(posedge clk_video);
		io_osd <= 1'b0;
		@(posedge clk_video);
		@(posedge clk_video);
	endtask

	task automatic write_block(input logic [2:0] block, input int count, input int salt);
		logic [buf_addr_w-1:0] addr;
		@(posedge clk_video);
		io_osd <= 1'b1;
		send_word({8'h00, cmd_write});
		send_word({13'd0, block});
		for (int i = 0; i < count; i++) begin
			// Address wraps at the end of the bitmap
			addr = buf_addr_w'(int'(block) * osd_width + i);
			send_word({8'h00, pattern_byte(addr, salt)});
			bitmap[addr] = pattern_byte(addr, salt);
		end
		close_frame();
	endtask

	task automatic send_enable(input logic en);
		@(posedge clk_video);
		io_osd <= 1'b1;
		send_word({8'h00, cmd_enable});
		send_word({15'd0, en});
		// Trailing word must be ignored
		send_word({15'd0, ~en});
		close_frame();
		model_enable = en;
	endtask

	task automatic send_bad();
		@(posedge clk_video);
		io_osd <= 1'b1;
		send_word(16'hab55);
		send_word(16'h0006);
		send_word(16'h00ff);
		close_frame();
	endtask

	task automatic wait_for_line(input int line);
		int n;
		n = 0;
		do begin
			@(posedge clk_video);
			n++;
			if (n > 2 * frame_cycles) begin
				fail_stop("timeout waiting for the video line that starts a host command");
			end
		end while (cur_line != line);
	endtask

	task automatic wait_frames(input int count);
		int target;
		int n;
		target = frame_count + count;
		n = 0;
		while (frame_count < target) begin
			@(posedge clk_video);
			n++;
			if (n > (count + 1) * frame_cycles) begin
				fail_stop("timeout waiting for the next rising edge of vs_in");
			end
		end
	endtask

	// Video source and reference model
	always @(posedge clk_video) begin : video_source
		logic [31:0] rnd;
		logic [23:0] pix;
		logic de;
		logic hs;
		logic vs;
		logic in_win;
		int vline;
		if (video_run) begin
			if (h_pos == 0 && v_pos == 0) begin
				frame_en = model_enable;
				vs_rises++;
				frame_count <= frame_count + 1;
			end
			vline = v_pos - v_blank;
			de = (v_pos >= v_blank) && (h_pos < act_w);
			hs = (h_pos >= hs_begin) && (h_pos < hs_end);
			vs = (v_pos < vs_lines);
			rnd = $random(seed);
			pix = rnd[23:0];
			// Geometry is known once a whole frame has been measured
			in_win = de && frame_en && (vs_rises >= 2)
				&& (h_pos >= h_start) && (h_pos < h_start + osd_width)
				&& (vline >= v_start) && (vline < v_start + osd_height);
			din <= pix;
			de_in <= de;
			hs_in <= hs;
			vs_in <= vs;
			exp_sync.push_back({de, hs, vs});
			if (in_win) begin
				exp_video.push_back(expected_blend(pix, h_pos - h_start, vline - v_start));
				win_pixels++;
			end else begin
				exp_video.push_back(pix);
			end
			cur_line <= v_pos;
			if (h_pos == line_len - 1) begin
				h_pos = 0;
				v_pos = (v_pos == frame_lines - 1) ? 0 : v_pos + 1;
			end else begin
				h_pos++;
			end
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk_video) begin
		if (exp_video.size() > pipe_delay) begin
			check_video("dout", exp_video.pop_front(), dout);
			check_sync("de_out/hs_out/vs_out", exp_sync.pop_front(), {de_out, hs_out, vs_out});
		end
	end

	initial begin : main
		step_t s;
		steps[0] = '{act_none, 3'd0, 12'd0, 4'd3, 1'b0};
		steps[1] = '{act_write, 3'd0, 12'd2048, 4'd1, 1'b0};
		steps[2] = '{act_enable, 3'd0, 12'd0, 4'd3, 1'b1};
		steps[3] = '{act_write, 3'd5, 12'd256, 4'd2, 1'b1};
		steps[4] = '{act_bad, 3'd0, 12'd0, 4'd2, 1'b1};
		steps[5] = '{act_disable, 3'd0, 12'd0, 4'd2, 1'b0};
		repeat (5) @(posedge clk_video);
		rst_n <= 1'b1;
		@(posedge clk_video);
		video_run <= 1'b1;
		for (int i = 0; i < num_steps; i++) begin
			s = steps[i];
			wait_for_line(host_line);
			case (s.act)
				act_write: write_block(s.block, int'(s.count), i);
				act_enable: send_enable(1'b1);
				act_disable: send_enable(1'b0);
				act_bad: send_bad();
				default: ;
			endcase
			wait_frames(int'(s.frames));
			check_level("osd_enable", s.en, osd_overlay_inst.osd_enable);
		end
		if (win_pixels > 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			fail_stop("no pixel fell inside the overlay window");
		end
	end

endmodule

//--- dv/osd_overlay_asserts.sv
//--------------------------------------------------------------------------
// OSD overlay assertions
//--------------------------------------------------------------------------
module osd_overlay_asserts (
	input logic clk_video,
	input logic rst_n,
	input logic io_osd,
	input logic wr_en,
	input logic de_in,
	input logic de_out,
	input osd_pkg::host_state_e state
);
	import osd_pkg::*;

	// Sync leaves the pipeline a fixed number of cycles later
	de_latency: assert property (
		@(posedge clk_video) disable iff (!rst_n)
		de_out == $past(de_in, pipe_delay)
	) else $error("de_out does not follow de_in by the pipeline delay");

	// Frame already open on the clock before any write
	write_framed: assert property (
		@(posedge clk_video) disable iff (!rst_n)
		wr_en |-> $past(io_osd)
	) else $error("bitmap write outside a host frame");

	state_legal: assert property (
		@(posedge clk_video) disable iff (!rst_n)
		state inside {st_idle, st_cmd, st_addr, st_data, st_skip}
	) else $error("command FSM in an illegal state");

endmodule

bind osd_overlay osd_overlay_asserts asserts_inst (
	.clk_video (clk_video),
	.rst_n     (rst_n),
	.io_osd    (io_osd),
	.wr_en     (wr_en),
	.de_in     (de_in),
	.de_out    (de_out),
	.state     (cmd_fsm_inst.state)
);

//--- hw/osd_overlay.sv
//--------------------------------------------------------------------------
// OSD overlay top level
//--------------------------------------------------------------------------
module osd_overlay (
	input  logic clk_video,
	input  logic rst_n,
	input  logic io_osd,
	input  logic io_strobe,
	input  logic [15:0] io_din,
	input  logic [23:0] din,
	input  logic de_in,
	input  logic hs_in,
	input  logic vs_in,
	output logic [23:0] dout,
	output logic de_out,
	output logic hs_out,
	output logic vs_out
);
	import osd_pkg::*;

	logic wr_en;
	logic [buf_addr_w-1:0] wr_addr;
	logic [7:0] wr_data;
	logic [buf_addr_w-1:0] rd_addr;
	logic [7:0] rd_data;
	logic osd_enable;

	osd_raster_if raster ();

	osd_cmd_fsm cmd_fsm_inst (
		.clk_video  (clk_video),
		.rst_n      (rst_n),
		.io_osd     (io_osd),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.osd_enable (osd_enable)
	);

	osd_raster_counter raster_counter_inst (
		.clk_video  (clk_video),
		.rst_n      (rst_n),
		.de_in      (de_in),
		.vs_in      (vs_in),
		.osd_enable (osd_enable),
		.raster     (raster.producer)
	);

	osd_char_buffer char_buffer_inst (
		.clk_video (clk_video),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	osd_pixel_mixer pixel_mixer_inst (
		.clk_video (clk_video),
		.rst_n     (rst_n),
		.din       (din),
		.de_in     (de_in),
		.hs_in     (hs_in),
		.vs_in     (vs_in),
		.rd_data   (rd_data),
		.raster    (raster.consumer),
		.rd_addr   (rd_addr),
		.dout      (dout),
		.de_out    (de_out),
		.hs_out    (hs_out),
		.vs_out    (vs_out)
	);

endmodule

//--- hw/osd_pixel_mixer.sv
//--------------------------------------------------------------------------
// OSD bitmap fetch and video blend
//--------------------------------------------------------------------------
module osd_pixel_mixer (
	input  logic clk_video,
	input  logic rst_n,
	input  logic [23:0] din,
	input  logic de_in,
	input  logic hs_in,
	input  logic vs_in,
	input  logic [7:0] rd_data,
	osd_raster_if.consumer raster,
	output logic [osd_pkg::buf_addr_w-1:0] rd_addr,
	output logic [23:0] dout,
	output logic de_out,
	output logic hs_out,
	output logic vs_out
);
	import osd_pkg::*;

	logic [23:0] din_q [mix_delay];
	logic [2:0] sync_q [pipe_delay];
	logic [2:0] bit_sel;
	logic win_d1;
	logic win_d2;
	logic pixel;
	logic [23:0] blend;

	// Eight rows share a byte, one bit each
	assign rd_addr = {raster.row[row_w-1:3], raster.col};

	always_comb begin
		for (int c = 0; c < 3; c++) begin
			blend[c*8 +: 8] = {pixel, pixel, osd_color[c], din_q[mix_delay-1][c*8+3 +: 5]};
		end
	end

	always_ff @(posedge clk_video) begin
		din_q[0] <= din;
		for (int i = 1; i < mix_delay; i++) begin
			din_q[i] <= din_q[i-1];
		end
		// Row is constant along a line
		if (raster.line_start) begin
			bit_sel <= raster.row[2:0];
		end
		pixel <= rd_data[bit_sel];
	end

	always_ff @(posedge clk_video or negedge rst_n) begin
		if (!rst_n) begin
			win_d1 <= 1'b0;
			win_d2 <= 1'b0;
			dout <= '0;
			for (int i = 0; i < pipe_delay; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			win_d1 <= raster.win_active;
			win_d2 <= win_d1;
			dout <= win_d2 ? blend : din_q[mix_delay-1];
			sync_q[0] <= {de_in, hs_in, vs_in};
			for (int i = 1; i < pipe_delay; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign de_out = sync_q[pipe_delay-1][2];
	assign hs_out = sync_q[pipe_delay-1][1];
	assign vs_out = sync_q[pipe_delay-1][0];

endmodule

//--- hw/osd_char_buffer.sv
//--------------------------------------------------------------------------
// OSD bitmap memory
//--------------------------------------------------------------------------
module osd_char_buffer (
	input  logic clk_video,
	input  logic wr_en,
	input  logic [osd_pkg::buf_addr_w-1:0] wr_addr,
	input  logic [7:0] wr_data,
	input  logic [osd_pkg::buf_addr_w-1:0] rd_addr,
	output logic [7:0] rd_data
);
	import osd_pkg::*;

	logic [7:0] mem [buf_depth];

	always_ff @(posedge clk_video) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		// Read data one cycle after the address
		rd_data <= mem[rd_addr];
	end

endmodule

//--- hw/osd_raster_counter.sv
//--------------------------------------------------------------------------
// OSD raster measurement and window position
//--------------------------------------------------------------------------
module osd_raster_counter (
	input  logic clk_video,
	input  logic rst_n,
	input  logic de_in,
	input  logic vs_in,
	input  logic osd_enable,
	osd_raster_if.producer raster
);
	import osd_pkg::*;

	logic de_q;
	logic vs_q;
	logic de_rise;
	logic de_fall;
	logic vs_rise;
	logic [cnt_w-1:0] h_cnt;
	logic [cnt_w-1:0] width;
	logic [cnt_w-1:0] v_line;
	logic [cnt_w-1:0] v_next;
	logic [cnt_w-1:0] height;
	logic en_frame;
	logic [cnt_w-1:0] cur_h;
	logic [cnt_w-1:0] cur_v;
	logic [cnt_w-1:0] h_start;
	logic [cnt_w-1:0] v_start;
	logic [cnt_w-1:0] h_off;
	logic [cnt_w-1:0] v_off;
	logic geom_ok;
	logic in_win;

	assign de_rise = de_in & ~de_q;
	assign de_fall = ~de_in & de_q;
	assign vs_rise = vs_in & ~vs_q;

	// Position of the pixel currently at the input
	assign cur_h = de_rise ? '0 : h_cnt + 1'b1;
	assign cur_v = de_rise ? v_next : v_line;

	// Centre the window in the measured picture
	assign h_start = (width - cnt_w'(osd_width)) >> 1;
	assign v_start = (height - cnt_w'(osd_height)) >> 1;
	assign geom_ok = (width >= cnt_w'(osd_width)) && (height >= cnt_w'(osd_height));

	assign h_off = cur_h - h_start;
	assign v_off = cur_v - v_start;
	assign in_win = de_in && en_frame && geom_ok
		&& (cur_h >= h_start) && (h_off < cnt_w'(osd_width))
		&& (cur_v >= v_start) && (v_off < cnt_w'(osd_height));

	always_ff @(posedge clk_video or negedge rst_n) begin
		if (!rst_n) begin
			de_q <= 1'b0;
			vs_q <= 1'b0;
			h_cnt <= '0;
			width <= '0;
			v_line <= '0;
			v_next <= '0;
			height <= '0;
			en_frame <= 1'b0;
			raster.win_active <= 1'b0;
			raster.col <= '0;
			raster.row <= '0;
			raster.line_start <= 1'b0;
		end else begin
			de_q <= de_in;
			vs_q <= vs_in;
			if (de_in) begin
				h_cnt <= cur_h;
			end
			// Last pixel index plus one gives the active width
			if (de_fall) begin
				width <= h_cnt + 1'b1;
			end
			if (de_rise) begin
				v_line <= v_next;
				v_next <= v_next + 1'b1;
			end
			if (vs_rise) begin
				height <= v_next;
				v_next <= '0;
				en_frame <= osd_enable;
			end
			raster.win_active <= in_win;
			raster.col <= h_off[col_w-1:0];
			raster.row <= v_off[row_w-1:0];
			raster.line_start <= de_rise;
		end
	end

endmodule

//--- hw/osd_cmd_fsm.sv
//--------------------------------------------------------------------------
// OSD host command decoder
//--------------------------------------------------------------------------
module osd_cmd_fsm (
	input  logic clk_video,
	input  logic rst_n,
	input  logic io_osd,
	input  logic io_strobe,
	input  logic [15:0] io_din,
	output logic wr_en,
	output logic [osd_pkg::buf_addr_w-1:0] wr_addr,
	output logic [7:0] wr_data,
	output logic osd_enable
);
	import osd_pkg::*;

	host_state_e state;
	osd_cmd_e cmd;
	logic strobe_q;
	logic strobe_rise;
	logic [buf_addr_w-1:0] wr_ptr;
	logic en_pending;
	logic en_valid;

	assign strobe_rise = io_strobe & ~strobe_q;

	// Data words go straight to the buffer on the strobe edge
	assign wr_en = (state == st_data) && io_osd && strobe_rise;
	assign wr_addr = wr_ptr;
	assign wr_data = io_din[7:0];

	always_ff @(posedge clk_video or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			cmd <= cmd_write;
			strobe_q <= 1'b0;
			wr_ptr <= '0;
			en_pending <= 1'b0;
			en_valid <= 1'b0;
			osd_enable <= 1'b0;
		end else begin
			strobe_q <= io_strobe;
			if (!io_osd) begin
				// End of frame commits a pending enable
				if (en_valid) begin
					osd_enable <= en_pending;
				end
				en_valid <= 1'b0;
				state <= st_idle;
			end else begin
				case (state)
					st_idle, st_cmd: begin
						if (strobe_rise) begin
							if (io_din[7:0] == cmd_write || io_din[7:0] == cmd_enable) begin
								cmd <= osd_cmd_e'(io_din[7:0]);
								state <= st_addr;
							end else begin
								state <= st_skip;
							end
						end else begin
							state <= st_cmd;
						end
					end
					st_addr: begin
						if (strobe_rise) begin
							if (cmd == cmd_write) begin
								// Base block selects a 256 byte region
								wr_ptr <= {io_din[2:0], {col_w{1'b0}}};
								state <= st_data;
							end else begin
								en_pending <= io_din[0];
								en_valid <= 1'b1;
								state <= st_skip;
							end
						end
					end
					st_data: begin
						if (strobe_rise) begin
							wr_ptr <= wr_ptr + 1'b1;
						end
					end
					st_skip: begin
						state <= st_skip;
					end
					default: begin
						state <= st_idle;
					end
				endcase
			end
		end
	end

endmodule

//--- hw/osd_raster_if.sv
//--------------------------------------------------------------------------
// OSD raster position link
//--------------------------------------------------------------------------
interface osd_raster_if;
	import osd_pkg::*;

	// Pixel inside the window with the overlay on
	logic win_active;
	logic [col_w-1:0] col;
	logic [row_w-1:0] row;
	// First active pixel of a line
	logic line_start;

	modport producer (
		output win_active,
		output col,
		output row,
		output line_start
	);

	modport consumer (
		input win_active,
		input col,
		input row,
		input line_start
	);

endinterface

//--- hw/osd_pkg.sv
//--------------------------------------------------------------------------
// OSD shared definitions
//--------------------------------------------------------------------------
package osd_pkg;

	// Overlay window size
	localparam int osd_width = 256;
	localparam int osd_height = 64;

	// Bitmap memory
	localparam int buf_depth = 2048;
	localparam int buf_addr_w = 11;

	// Raster coordinate widths
	localparam int col_w = 8;
	localparam int row_w = 6;
	localparam int cnt_w = 12;

	// One bit per channel, red in bit 2
	localparam logic [2:0] osd_color = 3'd4;

	// din to dout latency, and the share of it spent before the blend register
	localparam int pipe_delay = 4;
	localparam int mix_delay = pipe_delay - 1;

	typedef enum logic [7:0] {
		cmd_write = 8'h0c,
		cmd_enable = 8'h28
	} osd_cmd_e;

	typedef enum logic [2:0] {
		st_idle,
		st_cmd,
		st_addr,
		st_data,
		st_skip
	} host_state_e;

endpackage
